// File: verilog.f
hw/isa_pkg.sv
hw/ooo_pkg.sv
hw/insn_fifo.sv
hw/dispatch.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/ooo_dispatch_top.sv
verification/ooo_dispatch_sva.sv
verification/tb_ooo_dispatch.sv

// File: verification/tb_ooo_dispatch.sv
// Testbench for the dispatch subsystem
// Front end stimulus, execution unit model with random CDB delays,
// in-order reference model, commit and operand checks, timeout

`timescale 1ns/1ps

module tb_ooo_dispatch;

    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int          TOTAL_INSNS    = 24 + 80 + 48;
    localparam int          TIMEOUT_CYCLES = 40 * TOTAL_INSNS + 200;
    localparam logic [31:0] BASE_ADDR      = 32'h0000_1000;

    logic        clk;
    logic        arst_n;
    logic        push_valid;
    insn_entry_t push_data;
    logic        full;
    logic        cdb_valid;
    cdb_t        cdb;
    logic        issue_valid;
    issue_t      issue;
    logic        issue_ready;
    logic        commit_valid;
    commit_t     commit;

    logic [31:0] rng = 32'h7a1380b3;
    logic [31:0] exec_rng;
    string       test_name = "reset";
    int          errors = 0;
    int          cycles = 0;
    int          push_count = 0;
    int          commit_count = 0;
    int          issue_count = 0;
    int          stall_max = 0;
    int          stall_left = 0;
    bit          saw_full = 0;

    // Reference state in program order
    logic [31:0] ref_regs [32] = '{default: '0};
    commit_t     exp_commits [$];
    logic [31:0] exp_insn [256];
    logic [31:0] exp_a [256];
    logic [31:0] exp_b [256];
    bit          use_a [256];
    bit          use_b [256];
    bit          issued [256];

    // Execution unit results waiting for the CDB
    rob_tag_t    pend_tag [$];
    logic [31:0] pend_data [$];
    int          pend_wait [$];

    ooo_dispatch_top #(
        .FIFO_DEPTH(4),
        .RS_DEPTH  (4)
    ) u_ooo_dispatch_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .push_valid   (push_valid),
        .push_data    (push_data),
        .full         (full),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Architectural result of one instruction
    function automatic logic [31:0] ref_exec(input opcode_t opc, input logic [31:0] insn,
                                             input logic [31:0] pc, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        imm_i = {{20{insn[31]}}, insn[31:20]};
        imm_u = {insn[31:12], 12'h000};
        case (opc)
            OPCODE_OP:               ref_exec = a + b;
            OPCODE_OPIMM:            ref_exec = a + imm_i;
            OPCODE_LUI:              ref_exec = imm_u;
            OPCODE_AUIPC:            ref_exec = pc + imm_u;
            OPCODE_JAL, OPCODE_JALR: ref_exec = pc + 32'd4;
            default:                 ref_exec = '0;
        endcase
    endfunction

    // Registers limited to x0..x7 so dependencies are frequent
    function automatic logic [31:0] gen_insn(input bit dep, input logic [31:0] r);
        logic [31:0] insn;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        opcode_t     opc;
        int unsigned sel;
        rd  = {2'b00, r[2:0]};
        ra  = dep ? {2'b00, r[5:3]} : 5'd0;
        rb  = {2'b00, r[8:6]};
        sel = dep ? (r[31:28] % 7) : (r[31:28] % 3);
        case (sel)
            0:       opc = OPCODE_OPIMM;
            1:       opc = OPCODE_LUI;
            2:       opc = OPCODE_AUIPC;
            3:       opc = OPCODE_OP;
            4:       opc = OPCODE_JAL;
            5:       opc = OPCODE_JALR;
            default: opc = OPCODE_BRANCH;
        endcase
        insn = {r[27:16], ra, 3'b000, rd, opc};
        if (opc == OPCODE_OP) begin
            insn[31:20] = {7'b0000000, rb};
        end
        if (opc == OPCODE_BRANCH) begin
            insn[24:20] = rb;
        end
        return insn;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Record the expected outcome, then push until the queue accepts
    task automatic push_insn(input logic [31:0] insn);
        opcode_t     opc;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        commit_t     c;
        int          idx;
        opc = insn[6:0];
        ra  = insn[19:15];
        rb  = insn[24:20];
        idx = push_count;
        pc  = BASE_ADDR + 32'(4 * push_count);
        a   = (ra == 5'd0) ? 32'd0 : ref_regs[ra];
        b   = (rb == 5'd0) ? 32'd0 : ref_regs[rb];
        exp_insn[idx] = insn;
        exp_a[idx] = a;
        exp_b[idx] = b;
        use_a[idx] = opc inside {OPCODE_OPIMM, OPCODE_OP, OPCODE_JALR, OPCODE_BRANCH};
        use_b[idx] = opc inside {OPCODE_OP, OPCODE_BRANCH};
        c.op    = (opc inside {OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH}) ? ROB_OP_BR : ROB_OP_INT;
        c.rdest = (opc == OPCODE_BRANCH) ? 5'd0 : insn[11:7];
        c.data  = ref_exec(opc, insn, pc, a, b);
        if (c.rdest != 5'd0) begin
            ref_regs[c.rdest] = c.data;
        end
        exp_commits.push_back(c);
        push_data.insn  = insn;
        push_data.iaddr = pc;
        push_valid      = 1'b1;
        // Full only changes at an edge, so it is stable here
        while (full) begin
            saw_full = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        push_valid = 1'b0;
        push_count++;
    endtask

    task automatic run_phase(input string name, input int count, input bit dep,
                             input int gap_max, input int stall_cap);
        int gap;
        test_name = name;
        stall_max = stall_cap;
        for (int n = 0; n < count; n++) begin
            rng = xorshift(rng);
            push_insn(gen_insn(dep, rng));
            rng = xorshift(rng);
            gap = (gap_max > 0) ? int'(rng % (gap_max + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        while (exp_commits.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Execution unit: accepts issues, returns results after a random delay
    always @(posedge clk) begin
        int idx;
        int hit;
        if (arst_n && issue_valid && issue_ready) begin
            idx = int'((issue.iaddr - BASE_ADDR) >> 2);
            issue_count++;
            if (idx < 0 || idx >= push_count) begin
                errors++;
                $display("issued operation at %h was never pushed", issue.iaddr);
            end else begin
                if (issued[idx]) begin
                    errors++;
                    $display("operation at %h issued more than once", issue.iaddr);
                end
                issued[idx] = 1'b1;
                compare_value("issue insn", exp_insn[idx], issue.insn);
                compare_value("issue opcode", 32'(exp_insn[idx][6:0]), 32'(issue.opcode));
                // ROB tags are handed out in program order from entry 0
                compare_value("issue tag", 32'(idx % ROB_DEPTH), 32'(issue.dst_tag));
                if (use_a[idx]) begin
                    compare_value("operand rs1", exp_a[idx], issue.src_data[0]);
                end
                if (use_b[idx]) begin
                    compare_value("operand rs2", exp_b[idx], issue.src_data[1]);
                end
            end
            exec_rng = xorshift(exec_rng);
            pend_tag.push_back(issue.dst_tag);
            pend_data.push_back(ref_exec(issue.opcode, issue.insn, issue.iaddr,
                                         issue.src_data[0], issue.src_data[1]));
            pend_wait.push_back(int'(exec_rng % 7));
        end
        #1;
        hit = -1;
        for (int k = 0; k < pend_wait.size(); k++) begin
            if (pend_wait[k] > 0) begin
                pend_wait[k]--;
            end else if (hit < 0) begin
                hit = k;
            end
        end
        if (hit >= 0) begin
            cdb_valid = 1'b1;
            cdb.tag   = pend_tag[hit];
            cdb.data  = pend_data[hit];
            pend_tag.delete(hit);
            pend_data.delete(hit);
            pend_wait.delete(hit);
        end else begin
            cdb_valid = 1'b0;
        end
        // Random stretches of issue_ready low
        exec_rng = xorshift(exec_rng);
        if (stall_left > 0) begin
            stall_left--;
            issue_ready = 1'b0;
        end else if (stall_max > 0 && exec_rng[1:0] == 2'b00) begin
            stall_left  = int'(exec_rng[15:8]) % stall_max;
            issue_ready = 1'b0;
        end else begin
            issue_ready = 1'b1;
        end
    end

    // Commits compared in program order
    always @(posedge clk) begin
        commit_t exp_c;
        if (arst_n && commit_valid) begin
            commit_count++;
            if (exp_commits.size() == 0) begin
                errors++;
                $display("commit seen with no instruction outstanding");
            end else begin
                exp_c = exp_commits.pop_front();
                compare_value("commit op", 32'(exp_c.op), 32'(commit.op));
                compare_value("commit rdest", 32'(exp_c.rdest), 32'(commit.rdest));
                compare_value("commit data", exp_c.data, commit.data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in %s, %0d of %0d pushes committed",
                     cycles, test_name, commit_count, push_count);
            $display("Run ended with %0d errors plus timeout", errors);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        push_valid  = 1'b0;
        push_data   = '0;
        cdb_valid   = 1'b0;
        cdb         = '0;
        issue_ready = 1'b0;
        // Execution unit draws from its own stream
        exec_rng    = xorshift(rng);
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        run_phase("alu_independent", 24, 1'b0, 2, 3);
        run_phase("dependency_chain", 80, 1'b1, 2, 3);
        saw_full = 1'b0;
        run_phase("back_pressure", 48, 1'b1, 0, 30);
        if (!saw_full) begin
            errors++;
            $display("queue full never rose during the back-pressure test");
        end

        test_name = "summary";
        compare_value("commit count", 32'(push_count), 32'(commit_count));
        compare_value("issue count", 32'(push_count), 32'(issue_count));
        errors = errors + u_ooo_dispatch_top.u_ooo_dispatch_sva.fail_count;

        $display("Run finished: %0d instructions, %0d errors", push_count, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verification/ooo_dispatch_sva.sv
// Assertions for the dispatch subsystem
// Issue stability under back-pressure, queue overflow and reset behavior

`timescale 1ns/1ps

module ooo_dispatch_sva (
    input logic            clk,
    input logic            arst_n,
    input logic            push_valid,
    input logic            full,
    input logic            fifo_rd_en,
    input logic            issue_valid,
    input ooo_pkg::issue_t issue,
    input logic            issue_ready,
    input logic            commit_valid
);

    int fail_count = 0;

    // A stalled operation stays on the issue port unchanged
    assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
    else begin
        $error("issue port changed while stalled");
        fail_count++;
    end

    // Full queue with a pop must drop to not full, so the push was refused
    assert property (@(posedge clk) disable iff (!arst_n)
        push_valid && full && fifo_rd_en |=> !full)
    else begin
        $error("push accepted while queue full");
        fail_count++;
    end

    assert property (@(posedge clk) !arst_n |-> !commit_valid)
    else begin
        $error("commit_valid high during reset");
        fail_count++;
    end

endmodule

bind ooo_dispatch_top ooo_dispatch_sva u_ooo_dispatch_sva (
    .clk          (clk),
    .arst_n       (arst_n),
    .push_valid   (push_valid),
    .full         (full),
    .fifo_rd_en   (fifo_rd_en),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .commit_valid (commit_valid)
);

// File: hw/ooo_dispatch_top.sv
// Dispatch subsystem top level
// Instruction queue, dispatch, reorder buffer and reservation station

`timescale 1ns/1ps

module ooo_dispatch_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int RS_DEPTH   = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push_valid,
    input  ooo_pkg::insn_entry_t push_data,
    output logic                 full,
    input  logic                 cdb_valid,
    input  ooo_pkg::cdb_t        cdb,
    output logic                 issue_valid,
    output ooo_pkg::issue_t      issue,
    input  logic                 issue_ready,
    output logic                 commit_valid,
    output ooo_pkg::commit_t     commit
);

    import isa_pkg::*;
    import ooo_pkg::*;

    insn_entry_t                 fifo_head;
    logic                        fifo_empty;
    logic                        fifo_rd_en;
    logic                        rob_full;
    logic                        rob_alloc_en;
    rob_alloc_t                  rob_alloc;
    rob_tag_t                    rob_alloc_tag;
    logic [1:0][REG_ADDR_W-1:0]  lookup_rsrc;
    src_info_t [1:0]             lookup_src;
    logic                        rs_full;
    logic                        rs_alloc_en;
    rs_alloc_t                   rs_alloc;

    insn_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_insn_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .push_valid (push_valid),
        .push_data  (push_data),
        .full       (full),
        .rd_en      (fifo_rd_en),
        .empty      (fifo_empty),
        .head       (fifo_head)
    );

    dispatch u_dispatch (
        .fifo_head     (fifo_head),
        .fifo_empty    (fifo_empty),
        .fifo_rd_en    (fifo_rd_en),
        .rob_full      (rob_full),
        .rob_alloc_en  (rob_alloc_en),
        .rob_alloc     (rob_alloc),
        .rob_alloc_tag (rob_alloc_tag),
        .lookup_rsrc   (lookup_rsrc),
        .lookup_src    (lookup_src),
        .rs_full       (rs_full),
        .rs_alloc_en   (rs_alloc_en),
        .rs_alloc      (rs_alloc)
    );

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .alloc_en     (rob_alloc_en),
        .alloc        (rob_alloc),
        .alloc_tag    (rob_alloc_tag),
        .full         (rob_full),
        .lookup_rsrc  (lookup_rsrc),
        .lookup_src   (lookup_src),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    reservation_station #(
        .RS_DEPTH(RS_DEPTH)
    ) u_reservation_station (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc_en    (rs_alloc_en),
        .alloc       (rs_alloc),
        .full        (rs_full),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready)
    );

endmodule

// File: hw/reservation_station.sv
// Reservation station
// Entries wait on source tags, capture CDB results and issue oldest ready first
// Age counts the valid entries allocated before each entry

`timescale 1ns/1ps

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               alloc_en,
    input  ooo_pkg::rs_alloc_t alloc,
    output logic               full,
    input  logic               cdb_valid,
    input  ooo_pkg::cdb_t      cdb,
    output logic               issue_valid,
    output ooo_pkg::issue_t    issue,
    input  logic               issue_ready
);

    import ooo_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    rs_alloc_t           ent [RS_DEPTH];
    logic [RS_DEPTH-1:0] valid;
    logic [IDX_W-1:0]    age [RS_DEPTH];
    rs_alloc_t           alloc_woken;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    oldest_idx;
    logic [IDX_W-1:0]    held_idx;
    logic [IDX_W-1:0]    sel;
    logic [CNT_W-1:0]    occupancy;
    logic                any_ready;
    logic                held;
    logic                fire;

    always_comb begin
        free_idx   = '0;
        occupancy  = '0;
        oldest_idx = '0;
        any_ready  = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            occupancy = occupancy + CNT_W'(valid[i]);
            if (valid[i] && ent[i].src[0].rdy && ent[i].src[1].rdy &&
                (!any_ready || age[i] < age[oldest_idx])) begin
                any_ready  = 1'b1;
                oldest_idx = IDX_W'(i);
            end
        end
    end

    // Same-cycle wakeup of the entry being allocated
    always_comb begin
        alloc_woken = alloc;
        for (int j = 0; j < 2; j++) begin
            if (cdb_valid && !alloc.src[j].rdy && alloc.src[j].tag == cdb.tag) begin
                alloc_woken.src[j].rdy  = 1'b1;
                alloc_woken.src[j].data = cdb.data;
            end
        end
    end

    // A stalled issue keeps its entry until accepted
    assign sel         = held ? held_idx : oldest_idx;
    assign full        = &valid;
    assign issue_valid = any_ready;
    assign fire        = issue_valid && issue_ready;

    always_comb begin
        issue.opcode  = ent[sel].opcode;
        issue.insn    = ent[sel].insn;
        issue.iaddr   = ent[sel].iaddr;
        issue.dst_tag = ent[sel].dst_tag;
        for (int j = 0; j < 2; j++) begin
            issue.src_data[j] = ent[sel].src[j].data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid    <= '0;
            age      <= '{default: '0};
            held     <= 1'b0;
            held_idx <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (fire && valid[i] && age[i] > age[sel]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (fire) begin
                valid[sel] <= 1'b0;
            end
            if (alloc_en) begin
                valid[free_idx] <= 1'b1;
                age[free_idx]   <= IDX_W'(occupancy - CNT_W'(fire));
            end
            held     <= issue_valid && !issue_ready;
            held_idx <= sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc_en && free_idx == IDX_W'(i)) begin
                ent[i] <= alloc_woken;
            end else if (cdb_valid) begin
                for (int j = 0; j < 2; j++) begin
                    if (!ent[i].src[j].rdy && ent[i].src[j].tag == cdb.tag) begin
                        ent[i].src[j].rdy  <= 1'b1;
                        ent[i].src[j].data <= cdb.data;
                    end
                end
            end
        end
    end

endmodule

// File: hw/reorder_buffer.sv
// Reorder buffer
// Circular entry array with rename map and architectural register file
// Source lookup, CDB writeback and in-order commit

`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                alloc_en,
    input  ooo_pkg::rob_alloc_t                 alloc,
    output ooo_pkg::rob_tag_t                   alloc_tag,
    output logic                                full,
    input  logic [1:0][isa_pkg::REG_ADDR_W-1:0] lookup_rsrc,
    output ooo_pkg::src_info_t [1:0]            lookup_src,
    input  logic                                cdb_valid,
    input  ooo_pkg::cdb_t                       cdb,
    output logic                                commit_valid,
    output ooo_pkg::commit_t                    commit
);

    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;
    localparam int CNT_W    = ROB_TAG_W + 1;

    rob_tag_t              head;
    rob_tag_t              tail;
    logic [CNT_W-1:0]      count;
    logic [ROB_DEPTH-1:0]  ent_done;
    rob_op_t               ent_op    [ROB_DEPTH];
    logic [REG_ADDR_W-1:0] ent_rdest [ROB_DEPTH];
    logic [XLEN-1:0]       ent_data  [ROB_DEPTH];
    logic [NUM_REGS-1:0]   map_pend;
    rob_tag_t              map_tag   [NUM_REGS];
    logic [XLEN-1:0]       regfile   [NUM_REGS];
    logic [REG_ADDR_W-1:0] head_rd;
    logic                  rf_write;

    assign alloc_tag    = tail;
    assign full         = (count == CNT_W'(ROB_DEPTH));
    assign head_rd      = ent_rdest[head];
    assign commit_valid = ent_done[head];
    assign commit.op    = ent_op[head];
    assign commit.rdest = head_rd;
    assign commit.data  = ent_data[head];

    // Only integer and jump results reach the register file
    assign rf_write = commit_valid && (head_rd != '0) &&
                      (ent_op[head] == ROB_OP_INT || ent_op[head] == ROB_OP_BR);

    always_comb begin
        logic [REG_ADDR_W-1:0] rs;
        for (int j = 0; j < 2; j++) begin
            rs = lookup_rsrc[j];
            lookup_src[j].tag = '0;
            if (rs == '0) begin
                lookup_src[j].rdy  = 1'b1;
                lookup_src[j].data = '0;
            end else if (map_pend[rs]) begin
                // Renamed: take the result if it is already back
                lookup_src[j].tag  = map_tag[rs];
                lookup_src[j].rdy  = ent_done[map_tag[rs]];
                lookup_src[j].data = ent_data[map_tag[rs]];
            end else begin
                lookup_src[j].rdy  = 1'b1;
                lookup_src[j].data = regfile[rs];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
            map_pend <= '0;
            regfile  <= '{default: '0};
        end else begin
            if (cdb_valid) begin
                ent_done[cdb.tag] <= 1'b1;
            end
            if (commit_valid) begin
                ent_done[head] <= 1'b0;
                head           <= head + 1'b1;
                if (rf_write) begin
                    regfile[head_rd] <= ent_data[head];
                end
                if (map_tag[head_rd] == head) begin
                    map_pend[head_rd] <= 1'b0;
                end
            end
            // A rename in the same cycle overrides the commit clear
            if (alloc_en) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
                if (alloc.rdest != '0) begin
                    map_pend[alloc.rdest] <= 1'b1;
                end
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_op[tail]    <= alloc.op;
            ent_rdest[tail] <= alloc.rdest;
            if (alloc.rdest != '0) begin
                map_tag[alloc.rdest] <= tail;
            end
        end
        if (cdb_valid) begin
            ent_data[cdb.tag] <= cdb.data;
        end
    end

endmodule

// File: hw/dispatch.sv
// Dispatch stage
// Decodes the queue head, classifies it for the ROB and the reservation
// station, renames its sources and enables queue, ROB and RS together

`timescale 1ns/1ps

module dispatch (
    input  ooo_pkg::insn_entry_t                 fifo_head,
    input  logic                                 fifo_empty,
    output logic                                 fifo_rd_en,
    input  logic                                 rob_full,
    output logic                                 rob_alloc_en,
    output ooo_pkg::rob_alloc_t                  rob_alloc,
    input  ooo_pkg::rob_tag_t                    rob_alloc_tag,
    output logic [1:0][isa_pkg::REG_ADDR_W-1:0]  lookup_rsrc,
    input  ooo_pkg::src_info_t [1:0]             lookup_src,
    input  logic                                 rs_full,
    output logic                                 rs_alloc_en,
    output ooo_pkg::rs_alloc_t                   rs_alloc
);

    import isa_pkg::*;
    import ooo_pkg::*;

    opcode_t               opcode;
    logic [REG_ADDR_W-1:0] rdest;
    rob_op_t               rob_op;
    logic [REG_ADDR_W-1:0] rob_rdest;
    opcode_t               rs_opcode;
    logic [1:0]            force_rdy;
    logic                  stall;
    logic                  enable;

    // Instruction fields
    assign opcode         = fifo_head.insn[6:0];
    assign rdest          = fifo_head.insn[11:7];
    assign lookup_rsrc[0] = fifo_head.insn[19:15];
    assign lookup_rsrc[1] = fifo_head.insn[24:20];

    // One enable for all three units
    assign stall        = rob_full || rs_full;
    assign enable       = !stall && !fifo_empty;
    assign fifo_rd_en   = enable;
    assign rob_alloc_en = enable;
    assign rs_alloc_en  = enable;

    // Classify opcode; force_rdy marks sources the operation does not read
    always_comb begin
        rob_op    = ROB_OP_INT;
        rob_rdest = rdest;
        rs_opcode = opcode;
        force_rdy = 2'b00;
        case (opcode)
            OPCODE_OPIMM: force_rdy = 2'b10;
            OPCODE_LUI, OPCODE_AUIPC: force_rdy = 2'b11;
            OPCODE_OP: force_rdy = 2'b00;
            OPCODE_JAL: begin
                rob_op    = ROB_OP_BR;
                force_rdy = 2'b11;
            end
            OPCODE_JALR: begin
                rob_op    = ROB_OP_BR;
                force_rdy = 2'b10;
            end
            OPCODE_BRANCH: begin
                rob_op    = ROB_OP_BR;
                rob_rdest = '0;
            end
            OPCODE_LOAD: begin
                rob_op    = ROB_OP_LD;
                force_rdy = 2'b10;
            end
            OPCODE_STORE: begin
                rob_op    = ROB_OP_STR;
                rob_rdest = '0;
            end
            default: begin
                // Treated as a no-op immediate
                rs_opcode = OPCODE_OPIMM;
                rob_rdest = '0;
                force_rdy = 2'b11;
            end
        endcase
    end

    assign rob_alloc.op    = rob_op;
    assign rob_alloc.rdest = rob_rdest;
    assign rob_alloc.iaddr = fifo_head.iaddr;

    always_comb begin
        rs_alloc.opcode  = rs_opcode;
        rs_alloc.insn    = fifo_head.insn;
        rs_alloc.iaddr   = fifo_head.iaddr;
        rs_alloc.dst_tag = rob_alloc_tag;
        for (int j = 0; j < 2; j++) begin
            rs_alloc.src[j]     = lookup_src[j];
            rs_alloc.src[j].rdy = lookup_src[j].rdy || force_rdy[j];
        end
    end

endmodule

// File: hw/insn_fifo.sv
// Instruction queue between the front end and dispatch
// Circular buffer of instruction and address pairs, head shown combinationally

`timescale 1ns/1ps

module insn_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push_valid,
    input  ooo_pkg::insn_entry_t push_data,
    output logic                 full,
    input  logic                 rd_en,
    output logic                 empty,
    output ooo_pkg::insn_entry_t head
);

    import ooo_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    insn_entry_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];
    assign push  = push_valid && !full;
    assign pop   = rd_en && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: hw/ooo_pkg.sv
// Out-of-order core definitions
// ROB size and tag type, ROB operation codes, and the packed structs
// passed between queue, dispatch, ROB, reservation station and CDB

package ooo_pkg;

    import isa_pkg::*;

    localparam int ROB_TAG_W = 3;
    localparam int ROB_DEPTH = 1 << ROB_TAG_W;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    typedef enum logic [1:0] {
        ROB_OP_INT,
        ROB_OP_BR,
        ROB_OP_LD,
        ROB_OP_STR
    } rob_op_t;

    // One instruction queue slot
    typedef struct packed {
        logic [XLEN-1:0] insn;
        logic [XLEN-1:0] iaddr;
    } insn_entry_t;

    typedef struct packed {
        rob_op_t               op;
        logic [REG_ADDR_W-1:0] rdest;
        logic [XLEN-1:0]       iaddr;
    } rob_alloc_t;

    // Renamed source operand
    typedef struct packed {
        logic            rdy;
        rob_tag_t        tag;
        logic [XLEN-1:0] data;
    } src_info_t;

    typedef struct packed {
        opcode_t         opcode;
        logic [XLEN-1:0] insn;
        logic [XLEN-1:0] iaddr;
        rob_tag_t        dst_tag;
        src_info_t [1:0] src;
    } rs_alloc_t;

    // Operation sent to the execution unit
    typedef struct packed {
        opcode_t               opcode;
        logic [XLEN-1:0]       insn;
        logic [XLEN-1:0]       iaddr;
        rob_tag_t              dst_tag;
        logic [1:0][XLEN-1:0]  src_data;
    } issue_t;

    typedef struct packed {
        rob_tag_t        tag;
        logic [XLEN-1:0] data;
    } cdb_t;

    typedef struct packed {
        rob_op_t               op;
        logic [REG_ADDR_W-1:0] rdest;
        logic [XLEN-1:0]       data;
    } commit_t;

endpackage

// File: hw/isa_pkg.sv
// RV32I definitions shared by the dispatch subsystem
// Data and register index widths, opcode type and major opcode values

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [6:0] opcode_t;

    // Major opcodes, instruction bits [6:0]
    localparam opcode_t OPCODE_OPIMM  = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;

endpackage
